/* hw/axiMemPkg.sv */
// AXI memory slave shared definitions

package axiMemPkg;

	// Default widths and depth ----------------------------------
	localparam int ADDR_W_DEF    = 16;   // Byte address bits
	localparam int DATA_W_DEF    = 32;
	localparam int ID_W_DEF      = 4;
	localparam int MEM_WORDS_DEF = 1024; // Depth in data words

	localparam int LEN_W = 8; // AXI4 AxLEN, beats = len + 1

	// Encodings -------------------------------------------------
	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10,
		RSVD  = 2'b11
	} axiBurst_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01, // Never returned, no exclusive access
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axiResp_e;

	typedef enum logic [1:0] {
		WR_IDLE, // Waiting on AW
		WR_DATA, // Taking W beats
		WR_RESP  // B held until accepted
	} wrState_e;

	typedef enum logic [1:0] {
		RD_IDLE, // Waiting on AR
		RD_REQ,  // Memory request pending
		RD_WAIT, // Read data one cycle out
		RD_SEND  // R beat presented
	} rdState_e;

	// Burst legality --------------------------------------------
	// Only full width FIXED / INCR bursts are served
	function automatic axiResp_e burstCheck(
		input logic [63:0]      startAddr,
		input logic [LEN_W-1:0] len,
		input axiBurst_e        burst,
		input logic [2:0]       size,
		input int               dataW,
		input int               memWords
	);
		logic [63:0] startIdx;
		logic [63:0] lastIdx;
		startIdx = startAddr / 64'(dataW / 8); // Byte to word index
		lastIdx  = (burst == INCR) ? startIdx + 64'(len) : startIdx;
		if (!(burst == FIXED || burst == INCR))
			return SLVERR;
		if ((32'd8 << size) != dataW) // Narrow or oversized beat
			return SLVERR;
		if (lastIdx >= 64'(memWords)) // Last beat past the array
			return DECERR;
		return OKAY;
	endfunction

endpackage

/* hw/memPortIf.sv */
// Requester side memory port

interface memPortIf #(
	parameter int ADDR_W = 10, // Word index bits
	parameter int DATA_W = 32
);
	logic                  req;   // Held until gnt
	logic                  we;
	logic [ADDR_W-1:0]     addr;  // Word index, not byte address
	logic [DATA_W-1:0]     wdata;
	logic [DATA_W/8-1:0]   wstrb;
	logic                  gnt;   // Same cycle grant
	logic [DATA_W-1:0]     rdata; // Valid one cycle after a read grant

	modport requester (
		output req, we, addr, wdata, wstrb,
		input  gnt, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata, wstrb,
		output gnt, rdata
	);

endinterface

/* hw/sramBank.sv */
// Single port word memory

module sramBank #(
	parameter int DATA_W    = axiMemPkg::DATA_W_DEF,
	parameter int MEM_WORDS = axiMemPkg::MEM_WORDS_DEF
) (
	input  logic                         CLK,
	input  logic                         en,
	input  logic                         we,
	input  logic [$clog2(MEM_WORDS)-1:0] addr,
	input  logic [DATA_W-1:0]            wdata,
	input  logic [DATA_W/8-1:0]          wstrb,
	output logic [DATA_W-1:0]            rdata
);
	logic [DATA_W-1:0] ram [MEM_WORDS];

	always_ff @(posedge CLK) begin
		if (en) begin
			if (we) begin
				for (int b = 0; b < DATA_W / 8; b++) begin
					if (wstrb[b])
						ram[addr][b*8 +: 8] <= wdata[b*8 +: 8]; // Byte lane write
				end
			end else begin
				rdata <= ram[addr]; // Registered read, held on writes
			end
		end
	end

endmodule

/* hw/memArbiter.sv */
// Two port round-robin memory arbiter

module memArbiter #(
	parameter int ADDR_W = $clog2(axiMemPkg::MEM_WORDS_DEF), // Word index bits
	parameter int DATA_W = axiMemPkg::DATA_W_DEF
) (
	input  logic                CLK,
	input  logic                rst,
	memPortIf.arbiter           wrPort,
	memPortIf.arbiter           rdPort,
	// Single memory port
	output logic                ramEn,
	output logic                ramWe,
	output logic [ADDR_W-1:0]   ramAddr,
	output logic [DATA_W-1:0]   ramWdata,
	output logic [DATA_W/8-1:0] ramWstrb,
	input  logic [DATA_W-1:0]   ramRdata
);
	logic lastRd; // Read port won most recently
	logic wrWin;
	logic rdWin;
	logic tagRd;  // Read port owns the data coming back

	// Same cycle grant, loser of the last tie goes first
	assign wrWin = wrPort.req && (!rdPort.req || lastRd);
	assign rdWin = rdPort.req && !wrWin;

	assign wrPort.gnt = wrWin;
	assign rdPort.gnt = rdWin;

	// Winner's fields to the memory ----------------------
	assign ramEn    = wrWin || rdWin;
	assign ramWe    = wrWin ? wrPort.we    : (rdWin && rdPort.we);
	assign ramAddr  = wrWin ? wrPort.addr  : rdPort.addr;
	assign ramWdata = wrWin ? wrPort.wdata : rdPort.wdata;
	assign ramWstrb = wrWin ? wrPort.wstrb : rdPort.wstrb;

	always_ff @(posedge CLK) begin
		if (rst) begin
			lastRd <= 1'b1; // Write side first after reset
			tagRd  <= 1'b0;
		end else begin
			if (wrWin)
				lastRd <= 1'b0;
			else if (rdWin)
				lastRd <= 1'b1;
			tagRd <= rdWin; // Lines up with one cycle read latency
		end
	end

	// Steer returned word to its requester
	assign rdPort.rdata = tagRd ? ramRdata : '0;
	assign wrPort.rdata = tagRd ? '0 : ramRdata;

endmodule

/* hw/axiWriteEngine.sv */
// AXI4 write channel engine

module axiWriteEngine #(
	parameter int ADDR_W    = axiMemPkg::ADDR_W_DEF,
	parameter int DATA_W    = axiMemPkg::DATA_W_DEF,
	parameter int ID_W      = axiMemPkg::ID_W_DEF,
	parameter int MEM_WORDS = axiMemPkg::MEM_WORDS_DEF
) (
	input  logic                          CLK,
	input  logic                          rst,
	// Write address
	input  logic [ID_W-1:0]               awId,
	input  logic [ADDR_W-1:0]             awAddr,
	input  logic [axiMemPkg::LEN_W-1:0]   awLen,
	input  logic [2:0]                    awSize,
	input  axiMemPkg::axiBurst_e          awBurst,
	input  logic                          awValid,
	output logic                          awReady,
	// Write data
	input  logic [DATA_W-1:0]             wData,
	input  logic [DATA_W/8-1:0]           wStrb,
	input  logic                          wLast,
	input  logic                          wValid,
	output logic                          wReady,
	// Write response
	output logic [ID_W-1:0]               bId,
	output axiMemPkg::axiResp_e           bResp,
	output logic                          bValid,
	input  logic                          bReady,
	// Memory side
	memPortIf.requester                   mem
);
	import axiMemPkg::*;

	localparam int MEM_AW  = $clog2(MEM_WORDS);
	localparam int BYTE_SH = $clog2(DATA_W / 8); // Byte offset bits in a word

	wrState_e         state;
	logic [ID_W-1:0]  idReg;
	logic [MEM_AW-1:0] wordAddr;
	logic [LEN_W-1:0] beatsLeft; // Beats after the current one
	axiResp_e         respReg;
	axiBurst_e        burstReg;
	axiResp_e         awResp;
	logic             legal;
	logic             lastBeat;
	logic             wBeat;

	// Handshakes ----------------------------------------
	assign awResp   = burstCheck(64'(awAddr), awLen, awBurst, awSize, DATA_W, MEM_WORDS);
	assign legal    = (respReg == OKAY);
	assign awReady  = (state == WR_IDLE);
	assign lastBeat = (beatsLeft == '0); // Length counter alone ends the burst
	// Legal beats wait for the arbiter, error beats are swallowed
	assign wReady   = (state == WR_DATA) && (legal ? mem.gnt : 1'b1);
	assign wBeat    = wValid && wReady;

	assign bValid = (state == WR_RESP);
	assign bId    = idReg;
	assign bResp  = respReg;

	// Memory request straight from the W channel
	assign mem.req   = (state == WR_DATA) && legal && wValid; // WVALID holds, so req holds
	assign mem.we    = 1'b1;
	assign mem.addr  = wordAddr;
	assign mem.wdata = wData;
	assign mem.wstrb = wStrb;

	// FSM -----------------------------------------------
	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: begin
					if (awValid)
						state <= WR_DATA;
				end
				WR_DATA: begin
					if (wBeat && lastBeat)
						state <= WR_RESP; // B shows next cycle
				end
				WR_RESP: begin
					if (bReady)
						state <= WR_IDLE;
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// Burst context and address walk
	always_ff @(posedge CLK) begin
		if (awValid && awReady) begin
			idReg     <= awId;
			wordAddr  <= MEM_AW'(awAddr >> BYTE_SH);
			beatsLeft <= awLen;
			respReg   <= awResp;
			burstReg  <= awBurst;
		end else if (wBeat) begin
			beatsLeft <= beatsLeft - 1'b1;
			if (burstReg == INCR)
				wordAddr <= wordAddr + 1'b1; // FIXED keeps the word
		end
	end

endmodule

/* hw/axiReadEngine.sv */
// AXI4 read channel engine

module axiReadEngine #(
	parameter int ADDR_W    = axiMemPkg::ADDR_W_DEF,
	parameter int DATA_W    = axiMemPkg::DATA_W_DEF,
	parameter int ID_W      = axiMemPkg::ID_W_DEF,
	parameter int MEM_WORDS = axiMemPkg::MEM_WORDS_DEF
) (
	input  logic                          CLK,
	input  logic                          rst,
	// Read address
	input  logic [ID_W-1:0]               arId,
	input  logic [ADDR_W-1:0]             arAddr,
	input  logic [axiMemPkg::LEN_W-1:0]   arLen,
	input  logic [2:0]                    arSize,
	input  axiMemPkg::axiBurst_e          arBurst,
	input  logic                          arValid,
	output logic                          arReady,
	// Read data
	output logic [ID_W-1:0]               rId,
	output logic [DATA_W-1:0]             rData,
	output axiMemPkg::axiResp_e           rResp,
	output logic                          rLast,
	output logic                          rValid,
	input  logic                          rReady,
	// Memory side
	memPortIf.requester                   mem
);
	import axiMemPkg::*;

	localparam int MEM_AW  = $clog2(MEM_WORDS);
	localparam int BYTE_SH = $clog2(DATA_W / 8);

	rdState_e          state;
	logic [ID_W-1:0]   idReg;
	logic [MEM_AW-1:0] wordAddr;
	logic [LEN_W-1:0]  beatsLeft; // Zero on the final beat
	axiResp_e          respReg;
	axiBurst_e         burstReg;
	logic [DATA_W-1:0] dataReg;   // R output register
	axiResp_e          arResp;
	logic              legal;
	logic              rBeat;

	assign arResp  = burstCheck(64'(arAddr), arLen, arBurst, arSize, DATA_W, MEM_WORDS);
	assign legal   = (respReg == OKAY);
	assign arReady = (state == RD_IDLE);

	assign rValid = (state == RD_SEND);
	assign rBeat  = rValid && rReady;
	assign rId    = idReg;
	assign rData  = dataReg;
	assign rResp  = respReg;
	assign rLast  = (beatsLeft == '0);

	// Read-only requester
	assign mem.req   = (state == RD_REQ);
	assign mem.we    = 1'b0;
	assign mem.addr  = wordAddr;
	assign mem.wdata = '0;
	assign mem.wstrb = '0;

	// FSM -----------------------------------------------
	// REQ, WAIT, SEND per beat when uncontended
	always_ff @(posedge CLK) begin
		if (rst) begin
			state <= RD_IDLE;
		end else begin
			case (state)
				RD_IDLE: begin
					if (arValid)
						state <= (arResp == OKAY) ? RD_REQ : RD_SEND; // Errors skip memory
				end
				RD_REQ: begin
					if (mem.gnt)
						state <= RD_WAIT;
				end
				RD_WAIT: state <= RD_SEND; // rdata lands this cycle
				RD_SEND: begin
					if (rReady) begin
						if (beatsLeft == '0)
							state <= RD_IDLE;
						else
							state <= legal ? RD_REQ : RD_SEND;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// Burst context, address walk and data capture
	always_ff @(posedge CLK) begin
		if (arValid && arReady) begin
			idReg     <= arId;
			wordAddr  <= MEM_AW'(arAddr >> BYTE_SH);
			beatsLeft <= arLen;
			respReg   <= arResp;
			burstReg  <= arBurst;
			dataReg   <= '0; // Error bursts stream zeros
		end else begin
			if (state == RD_WAIT)
				dataReg <= mem.rdata;
			if (rBeat) begin
				beatsLeft <= beatsLeft - 1'b1;
				if (burstReg == INCR)
					wordAddr <= wordAddr + 1'b1;
			end
		end
	end

endmodule

/* hw/axiMemSlave.sv */
// AXI4 slave memory top level

module axiMemSlave #(
	parameter int ADDR_W    = axiMemPkg::ADDR_W_DEF,
	parameter int DATA_W    = axiMemPkg::DATA_W_DEF,
	parameter int ID_W      = axiMemPkg::ID_W_DEF,
	parameter int MEM_WORDS = axiMemPkg::MEM_WORDS_DEF
) (
	input  logic                        CLK,
	input  logic                        rst,
	// Write address
	input  logic [ID_W-1:0]             awId,
	input  logic [ADDR_W-1:0]           awAddr,
	input  logic [axiMemPkg::LEN_W-1:0] awLen,
	input  logic [2:0]                  awSize,
	input  axiMemPkg::axiBurst_e        awBurst,
	input  logic                        awValid,
	output logic                        awReady,
	// Write data
	input  logic [DATA_W-1:0]           wData,
	input  logic [DATA_W/8-1:0]         wStrb,
	input  logic                        wLast,
	input  logic                        wValid,
	output logic                        wReady,
	// Write response
	output logic [ID_W-1:0]             bId,
	output axiMemPkg::axiResp_e         bResp,
	output logic                        bValid,
	input  logic                        bReady,
	// Read address
	input  logic [ID_W-1:0]             arId,
	input  logic [ADDR_W-1:0]           arAddr,
	input  logic [axiMemPkg::LEN_W-1:0] arLen,
	input  logic [2:0]                  arSize,
	input  axiMemPkg::axiBurst_e        arBurst,
	input  logic                        arValid,
	output logic                        arReady,
	// Read data
	output logic [ID_W-1:0]             rId,
	output logic [DATA_W-1:0]           rData,
	output axiMemPkg::axiResp_e         rResp,
	output logic                        rLast,
	output logic                        rValid,
	input  logic                        rReady
);
	localparam int MEM_AW = $clog2(MEM_WORDS);

	// One memory port per engine
	memPortIf #(.ADDR_W(MEM_AW), .DATA_W(DATA_W)) wrMem ();
	memPortIf #(.ADDR_W(MEM_AW), .DATA_W(DATA_W)) rdMem ();

	logic                ramEn;
	logic                ramWe;
	logic [MEM_AW-1:0]   ramAddr;
	logic [DATA_W-1:0]   ramWdata;
	logic [DATA_W/8-1:0] ramWstrb;
	logic [DATA_W-1:0]   ramRdata;

	// Engines ---------------------------------------------
	axiWriteEngine #(
		.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W), .MEM_WORDS(MEM_WORDS)
	) u_wrEngine (
		.CLK, .rst,
		.awId, .awAddr, .awLen, .awSize, .awBurst, .awValid, .awReady,
		.wData, .wStrb, .wLast, .wValid, .wReady,
		.bId, .bResp, .bValid, .bReady,
		.mem(wrMem.requester)
	);

	axiReadEngine #(
		.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W), .MEM_WORDS(MEM_WORDS)
	) u_rdEngine (
		.CLK, .rst,
		.arId, .arAddr, .arLen, .arSize, .arBurst, .arValid, .arReady,
		.rId, .rData, .rResp, .rLast, .rValid, .rReady,
		.mem(rdMem.requester)
	);

	// Shared memory ---------------------------------------
	memArbiter #(.ADDR_W(MEM_AW), .DATA_W(DATA_W)) u_arbiter (
		.CLK, .rst,
		.wrPort(wrMem.arbiter),
		.rdPort(rdMem.arbiter),
		.ramEn, .ramWe, .ramAddr, .ramWdata, .ramWstrb, .ramRdata
	);

	sramBank #(.DATA_W(DATA_W), .MEM_WORDS(MEM_WORDS)) u_sram (
		.CLK,
		.en(ramEn),
		.we(ramWe),
		.addr(ramAddr),
		.wdata(ramWdata),
		.wstrb(ramWstrb),
		.rdata(ramRdata)
	);

endmodule

/* tb/tbAxiMemSlave.sv */
// AXI memory slave testbench

module tbAxiMemSlave;
	import axiMemPkg::*;

	localparam int ADDR_W    = ADDR_W_DEF;
	localparam int DATA_W    = DATA_W_DEF;
	localparam int ID_W      = ID_W_DEF;
	localparam int MEM_WORDS = MEM_WORDS_DEF;
	localparam int STRB_W    = DATA_W / 8;
	localparam int MAX_WAIT  = 200; // Cycles allowed per handshake

	logic                CLK;
	logic                rst;
	logic [ID_W-1:0]     awId;
	logic [ADDR_W-1:0]   awAddr;
	logic [LEN_W-1:0]    awLen;
	logic [2:0]          awSize;
	axiBurst_e           awBurst;
	logic                awValid;
	logic                awReady;
	logic [DATA_W-1:0]   wData;
	logic [STRB_W-1:0]   wStrb;
	logic                wLast;
	logic                wValid;
	logic                wReady;
	logic [ID_W-1:0]     bId;
	axiResp_e            bResp;
	logic                bValid;
	logic                bReady;
	logic [ID_W-1:0]     arId;
	logic [ADDR_W-1:0]   arAddr;
	logic [LEN_W-1:0]    arLen;
	logic [2:0]          arSize;
	axiBurst_e           arBurst;
	logic                arValid;
	logic                arReady;
	logic [ID_W-1:0]     rId;
	logic [DATA_W-1:0]   rData;
	axiResp_e            rResp;
	logic                rLast;
	logic                rValid;
	logic                rReady;

	logic [DATA_W-1:0] shadow [MEM_WORDS]; // Reference copy of the memory
	int                seed;

	axiMemSlave #(
		.ADDR_W(ADDR_W), .DATA_W(DATA_W), .ID_W(ID_W), .MEM_WORDS(MEM_WORDS)
	) u_dut (
		.CLK, .rst,
		.awId, .awAddr, .awLen, .awSize, .awBurst, .awValid, .awReady,
		.wData, .wStrb, .wLast, .wValid, .wReady,
		.bId, .bResp, .bValid, .bReady,
		.arId, .arAddr, .arLen, .arSize, .arBurst, .arValid, .arReady,
		.rId, .rData, .rResp, .rLast, .rValid, .rReady
	);

	always #50 CLK = ~CLK; // 100 unit period

	// Reporting and compares ----------------
	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkResp(input string name, input axiResp_e exp, input axiResp_e act);
		if (act !== exp)
			reportFail($sformatf("mismatch %s expected %s actual %s (%b)",
				name, exp.name(), act.name(), act));
	endtask

	task automatic checkData(input string name, input logic [DATA_W-1:0] exp,
			input logic [DATA_W-1:0] act);
		if (act !== exp)
			reportFail($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkId(input string name, input logic [ID_W-1:0] exp,
			input logic [ID_W-1:0] act);
		if (act !== exp)
			reportFail($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic checkLast(input string name, input logic exp, input logic act);
		if (act !== exp)
			reportFail($sformatf("mismatch %s expected %b actual %b", name, exp, act));
	endtask

	// Reference rules -----------------------
	// Full width FIXED or INCR only, last beat must stay inside the array
	function automatic axiResp_e respRule(input int addr, input int len,
			input axiBurst_e burst, input int size);
		int lastWord;
		if (burst != FIXED && burst != INCR)
			return SLVERR;
		if (size != $clog2(STRB_W))
			return SLVERR;
		lastWord = addr / STRB_W + ((burst == INCR) ? len : 0);
		if (lastWord >= MEM_WORDS)
			return DECERR;
		return OKAY;
	endfunction

	function automatic int wordOf(input int addr, input axiBurst_e burst, input int beat);
		return addr / STRB_W + ((burst == INCR) ? beat : 0); // FIXED stays put
	endfunction

	function automatic logic randomReady();
		return ($random(seed) & 3) != 0; // High about three cycles in four
	endfunction

	// Write burst ---------------------------
	task automatic writeBurst(input int cmd, input int id, input int addr, input int len,
			input axiBurst_e burst, input int size, input logic [DATA_W-1:0] first,
			input logic [STRB_W-1:0] strb);
		axiResp_e          expResp;
		logic [DATA_W-1:0] beatData;
		int                waited;
		int                i;
		int                b;
		expResp = respRule(addr, len, burst, size);
		@(negedge CLK);
		awId    = ID_W'(id);
		awAddr  = ADDR_W'(addr);
		awLen   = LEN_W'(len);
		awSize  = 3'(size);
		awBurst = burst;
		awValid = 1'b1;
		waited  = 0;
		@(posedge CLK);
		while (!awReady) begin
			waited++;
			if (waited >= MAX_WAIT)
				reportFail("timeout: write address channel stalled, AWREADY never rose");
			@(posedge CLK);
		end
		for (i = 0; i <= len; i++) begin
			@(negedge CLK);
			awValid = 1'b0;
			wData   = first + DATA_W'(i); // Beat index added to the first word
			wStrb   = strb;
			wLast   = (i == len);
			wValid  = 1'b1;
			waited  = 0;
			@(posedge CLK);
			while (!wReady) begin
				waited++;
				if (waited >= MAX_WAIT)
					reportFail("timeout: write data channel stalled, WREADY never rose");
				@(posedge CLK);
			end
		end
		@(negedge CLK);
		wValid = 1'b0;
		wLast  = 1'b0;
		bReady = randomReady();
		waited = 0;
		@(posedge CLK);
		while (!(bValid && bReady)) begin
			waited++;
			if (waited >= MAX_WAIT)
				reportFail("timeout: write response channel stalled, no B handshake");
			@(negedge CLK);
			bReady = randomReady();
			@(posedge CLK);
		end
		checkId($sformatf("cmd %0d BID", cmd), ID_W'(id), bId);
		checkResp($sformatf("cmd %0d BRESP", cmd), expResp, bResp);
		@(negedge CLK);
		bReady = 1'b0;
		checkLast($sformatf("cmd %0d BVALID after response", cmd), 1'b0, bValid);
		if (expResp == OKAY) begin
			for (i = 0; i <= len; i++) begin
				beatData = first + DATA_W'(i);
				for (b = 0; b < STRB_W; b++)
					if (strb[b])
						shadow[wordOf(addr, burst, i)][b*8 +: 8] = beatData[b*8 +: 8];
			end
		end
	endtask

	// Read burst ----------------------------
	task automatic readBurst(input int cmd, input int id, input int addr, input int len,
			input axiBurst_e burst, input int size);
		axiResp_e          expResp;
		logic [DATA_W-1:0] expData [256];
		int                waited;
		int                i;
		string             tag;
		expResp = respRule(addr, len, burst, size);
		for (i = 0; i <= len; i++)
			expData[i] = (expResp == OKAY) ? shadow[wordOf(addr, burst, i)] : '0;
		@(negedge CLK);
		arId    = ID_W'(id);
		arAddr  = ADDR_W'(addr);
		arLen   = LEN_W'(len);
		arSize  = 3'(size);
		arBurst = burst;
		arValid = 1'b1;
		waited  = 0;
		@(posedge CLK);
		while (!arReady) begin
			waited++;
			if (waited >= MAX_WAIT)
				reportFail("timeout: read address channel stalled, ARREADY never rose");
			@(posedge CLK);
		end
		for (i = 0; i <= len; i++) begin
			tag = $sformatf("cmd %0d R beat %0d", cmd, i);
			@(negedge CLK);
			arValid = 1'b0;
			rReady  = randomReady();
			waited  = 0;
			@(posedge CLK);
			while (!(rValid && rReady)) begin
				waited++;
				if (waited >= MAX_WAIT)
					reportFail("timeout: read data channel stalled, no R handshake");
				@(negedge CLK);
				rReady = randomReady();
				@(posedge CLK);
			end
			checkData({tag, " RDATA"}, expData[i], rData);
			checkResp({tag, " RRESP"}, expResp, rResp);
			checkId({tag, " RID"}, ID_W'(id), rId);
			checkLast({tag, " RLAST"}, (i == len), rLast);
		end
		@(negedge CLK);
		rReady = 1'b0;
		checkLast($sformatf("cmd %0d RVALID after RLAST", cmd), 1'b0, rValid); // No extra beat
	endtask

	// Main sequence -------------------------
	initial begin
		int                fd;
		int                c;
		int                n;
		int                cmd;
		int                id;
		int                addr;
		int                len;
		int                burstV;
		int                size;
		int                strbV;
		int                addr2;
		logic [DATA_W-1:0] data;
		axiBurst_e         burst;
		seed    = 32'hd7d8;
		CLK     = 1'b0;
		rst     = 1'b1;
		awId    = '0;
		awAddr  = '0;
		awLen   = '0;
		awSize  = '0;
		awBurst = FIXED;
		awValid = 1'b0;
		wData   = '0;
		wStrb   = '0;
		wLast   = 1'b0;
		wValid  = 1'b0;
		bReady  = 1'b0;
		arId    = '0;
		arAddr  = '0;
		arLen   = '0;
		arSize  = '0;
		arBurst = FIXED;
		arValid = 1'b0;
		rReady  = 1'b0;
		repeat (10) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;
		@(posedge CLK);
		// Idle state straight out of reset
		checkLast("after reset BVALID", 1'b0, bValid);
		checkLast("after reset RVALID", 1'b0, rValid);
		checkLast("after reset WREADY", 1'b0, wReady);
		checkLast("after reset AWREADY", 1'b1, awReady);
		checkLast("after reset ARREADY", 1'b1, arReady);

		fd = $fopen("tb/axiMemStimulus.txt", "r");
		if (fd == 0)
			reportFail("could not open stimulus file tb/axiMemStimulus.txt");
		cmd = 0;
		c   = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				while (c != -1 && c != 10) // Skip comment to end of line
					c = $fgetc(fd);
			end else if (c == "W" || c == "R" || c == "B") begin
				n = $fscanf(fd, " %h %h %h %h %h %h %h %h",
					id, addr, len, burstV, size, data, strbV, addr2);
				if (n != 8)
					reportFail($sformatf("stimulus command %0d has missing fields", cmd));
				burst = axiBurst_e'(burstV[1:0]);
				if (c == "W") begin
					writeBurst(cmd, id, addr, len, burst, size, data, STRB_W'(strbV));
				end else if (c == "R") begin
					readBurst(cmd, id, addr, len, burst, size);
				end else begin
					fork // Both engines compete for the memory
						writeBurst(cmd, id, addr, len, burst, size, data, STRB_W'(strbV));
						readBurst(cmd, (id + 1) % 16, addr2, len, burst, size);
					join
				end
				cmd++;
			end else if (c > 32) begin
				reportFail($sformatf("unexpected character %0d in stimulus file", c));
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
		if (cmd < 1) begin
			reportFail("stimulus file held no commands");
		end else begin
			$display("*** TEST PASSED ***");
			$finish;
		end
	end

endmodule

/* tb/axiMemStimulus.txt */
# op id addr len burst size data strb addr2, all fields hex after op
# op W write, R read, B write at addr with read at addr2; burst 0 FIXED 1 INCR 2 WRAP
W 1 0000 07 1 2 a0000000 f 0000
R 2 0000 07 1 2 00000000 0 0000
W 3 0040 03 0 2 b0000000 f 0000
R 4 0040 03 0 2 00000000 0 0000
# partial strobes over earlier data
W 5 0000 03 1 2 11223344 5 0000
R 6 0000 07 1 2 00000000 0 0000
# WRAP and narrow bursts
W 7 0000 03 2 2 deadbeef f 0000
W 8 0000 03 1 1 deadbeef f 0000
R 9 0000 03 2 2 00000000 0 0000
R a 0000 03 1 0 00000000 0 0000
# end of the array and past it
W b 0ff0 03 1 2 c0000000 f 0000
W c 0ff0 07 1 2 eeeeeeee f 0000
R d 0ff0 07 1 2 00000000 0 0000
R e 0ff0 03 1 2 00000000 0 0000
R f 0000 07 1 2 00000000 0 0000
# concurrent write and read, different regions
B 1 0200 07 1 2 d0000000 f 0000
R 2 0200 07 1 2 00000000 0 0000

/* vlog.f */
hw/axiMemPkg.sv
hw/memPortIf.sv
hw/sramBank.sv
hw/memArbiter.sv
hw/axiWriteEngine.sv
hw/axiReadEngine.sv
hw/axiMemSlave.sv
tb/tbAxiMemSlave.sv
